// File: rv_alu.sv
module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result,
    output logic            cond
);

    import rv_pkg::*;

    word_t diff;

    assign diff = a - b;  // Shared by SUB and the compares

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = diff;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_pass_b: result = b;
            default:    result = diff;
        endcase
    end

    // Branch condition, only meaningful for eq and ne
    always_comb begin
        case (op)
            alu_eq:  cond = (diff == '0);
            alu_ne:  cond = (diff != '0);
            default: cond = 1'b0;
        endcase
    end

endmodule

// File: rv_core.sv
module rv_core #(
    parameter rv_pkg::word_t reset_pc = '0
) (
    input  logic              clk,
    input  logic              reset,
    output rv_pkg::word_t     im_addr,
    input  rv_pkg::word_t     inst,
    output rv_pkg::word_t     dm_addr,
    output rv_pkg::word_t     dm_wdata,
    output logic              dm_wr,
    output logic              dm_rd,
    input  rv_pkg::word_t     dm_rdata,
    input  rv_pkg::reg_addr_t reg_sel,
    output rv_pkg::word_t     reg_data
);

    import rv_pkg::*;

    word_t     pc;
    word_t     pc_next;
    word_t     target;
    logic      redirect;
    if_id_t    if_id_d, if_id_q;
    id_ex_t    id_ex_d, id_ex_q;
    ex_mem_t   ex_mem_d, ex_mem_q;
    mem_wb_t   mem_wb_d, mem_wb_q;
    word_t     dec_inst;
    reg_addr_t rs1_id, rs2_id, rd_id;
    word_t     imm_id;
    ctrl_t     ctrl_id;
    word_t     rs1_data, rs2_data;
    logic      stall, flush_if_id, flush_id_ex;
    fwd_sel_t  fwd_a, fwd_b;
    word_t     mem_fwd_data, wb_data;
    word_t     op_a, fwd_b_data, op_b;
    word_t     alu_result;
    logic      alu_cond;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // Fetch
    assign pc_next = redirect ? target : pc + word_t'(4);
    assign im_addr = pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    assign if_id_d = '{pc: pc, inst: inst, valid: 1'b1};

    rv_pipe_reg #(.payload_t(if_id_t)) i_if_id (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush_if_id),
        .d(if_id_d), .q(if_id_q)
    );

    // Decode
    assign dec_inst = if_id_q.valid ? if_id_q.inst : nop_instruction;

    rv_decoder i_decoder (
        .inst(dec_inst), .rs1(rs1_id), .rs2(rs2_id), .rd(rd_id),
        .imm(imm_id), .ctrl(ctrl_id)
    );

    rv_regfile i_regfile (
        .clk(clk), .reset(reset),
        .wr_en(mem_wb_q.valid && mem_wb_q.reg_write),
        .wr_addr(mem_wb_q.rd), .wr_data(wb_data),
        .rd_addr_a(rs1_id), .rd_addr_b(rs2_id),
        .rd_data_a(rs1_data), .rd_data_b(rs2_data),
        .dbg_addr(reg_sel), .dbg_data(reg_data)
    );

    assign id_ex_d = '{pc: if_id_q.pc, rs1_data: rs1_data, rs2_data: rs2_data, imm: imm_id,
                       rs1: rs1_id, rs2: rs2_id, rd: rd_id, ctrl: ctrl_id,
                       valid: if_id_q.valid};

    rv_pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flush_id_ex),
        .d(id_ex_d), .q(id_ex_q)
    );

    // Execute
    assign op_a       = fwd_mux(fwd_a, id_ex_q.rs1_data, mem_fwd_data, wb_data);
    assign fwd_b_data = fwd_mux(fwd_b, id_ex_q.rs2_data, mem_fwd_data, wb_data);
    assign op_b       = id_ex_q.ctrl.alu_src_imm ? id_ex_q.imm : fwd_b_data;

    rv_alu i_alu (
        .a(op_a), .b(op_b), .op(id_ex_q.ctrl.alu_op), .result(alu_result), .cond(alu_cond)
    );

    assign redirect = id_ex_q.valid && (id_ex_q.ctrl.is_jal || id_ex_q.ctrl.is_jalr
                                        || (id_ex_q.ctrl.is_branch && alu_cond));
    assign target   = id_ex_q.ctrl.is_jalr ? {alu_result[xlen-1:1], 1'b0}  // rs1 + offset
                                           : id_ex_q.pc + id_ex_q.imm;

    rv_hazard_unit i_hazard_unit (
        .rs1_id(rs1_id), .rs2_id(rs2_id), .id_ex(id_ex_q), .ex_mem(ex_mem_q),
        .mem_wb(mem_wb_q), .redirect(redirect), .stall(stall),
        .flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    assign ex_mem_d = '{pc: id_ex_q.pc, alu_result: alu_result, store_data: fwd_b_data,
                        rd: id_ex_q.rd, reg_write: id_ex_q.ctrl.reg_write,
                        mem_read: id_ex_q.ctrl.mem_read, mem_write: id_ex_q.ctrl.mem_write,
                        wb_sel: id_ex_q.ctrl.wb_sel, valid: id_ex_q.valid};

    rv_pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // Memory
    assign dm_addr  = ex_mem_q.alu_result;
    assign dm_wdata = ex_mem_q.store_data;
    assign dm_wr    = ex_mem_q.valid && ex_mem_q.mem_write;
    assign dm_rd    = ex_mem_q.valid && ex_mem_q.mem_read;

    always_comb begin
        case (ex_mem_q.wb_sel)
            wb_mem:  mem_fwd_data = dm_rdata;
            wb_pc4:  mem_fwd_data = ex_mem_q.pc + word_t'(4);  // Return address
            default: mem_fwd_data = ex_mem_q.alu_result;
        endcase
    end

    assign mem_wb_d = '{pc: ex_mem_q.pc, alu_result: ex_mem_q.alu_result, mem_data: dm_rdata,
                        rd: ex_mem_q.rd, reg_write: ex_mem_q.reg_write,
                        wb_sel: ex_mem_q.wb_sel, valid: ex_mem_q.valid};

    rv_pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    // Write-back
    always_comb begin
        case (mem_wb_q.wb_sel)
            wb_mem:  wb_data = mem_wb_q.mem_data;
            wb_pc4:  wb_data = mem_wb_q.pc + word_t'(4);
            default: wb_data = mem_wb_q.alu_result;
        endcase
    end

endmodule

// File: rv_core_asserts.sv
module rv_core_asserts (
    input logic            clk,
    input logic            reset,
    input logic            dm_wr,
    input logic            dm_rd,
    input logic            stall,
    input rv_pkg::word_t   im_addr,
    input rv_pkg::id_ex_t  id_ex
);

    logic store_seen;  // A store has moved on into the memory stage

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            store_seen <= 1'b0;
        end else if (id_ex.valid && id_ex.ctrl.mem_write) begin
            store_seen <= 1'b1;
        end
    end

    no_dual_access: assert property (@(posedge clk) disable iff (reset) !(dm_wr && dm_rd))
        else $error("dm_wr and dm_rd are high in the same cycle");

    stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
                                     stall |=> $stable(im_addr))
        else $error("im_addr moved during a load-use stall");

    // No write before the first store shows up in memory stage
    no_early_write: assert property (@(posedge clk) disable iff (reset)
        !store_seen |-> !dm_wr)
        else $error("dm_wr raised before any store reached the memory stage");

endmodule

bind rv_core rv_core_asserts i_rv_core_asserts (
    .clk(clk), .reset(reset), .dm_wr(dm_wr), .dm_rd(dm_rd), .stall(stall),
    .im_addr(im_addr), .id_ex(id_ex_q)
);

// File: rv_decoder.sv
module rv_decoder (
    input  rv_pkg::word_t     inst,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::word_t     imm,
    output rv_pkg::ctrl_t     ctrl
);

    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      j_imm;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'b0};
    assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl = '0;  // Bubble unless a case below matches
        imm  = i_imm;
        case (opcode)
            op_reg: begin
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = alu_add;
                    {7'b0100000, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'b0000000, 3'b111}: ctrl.alu_op = alu_and;
                    {7'b0000000, 3'b110}: ctrl.alu_op = alu_or;
                    {7'b0000000, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'b0000000, 3'b010}: ctrl.alu_op = alu_slt;
                    default:              ctrl.reg_write = 1'b0;
                endcase
            end
            op_imm: begin
                ctrl.reg_write   = (funct3 == 3'b000);  // ADDI only
                ctrl.alu_src_imm = 1'b1;
            end
            op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_pass_b;
                imm              = u_imm;
            end
            op_load: begin
                ctrl.reg_write   = (funct3 == 3'b010);
                ctrl.mem_read    = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = wb_mem;
            end
            op_store: begin
                ctrl.mem_write   = (funct3 == 3'b010);
                ctrl.alu_src_imm = 1'b1;
                imm              = s_imm;
            end
            op_branch: begin
                ctrl.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl.alu_op    = funct3[0] ? alu_ne : alu_eq;
                imm            = b_imm;
            end
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.wb_sel    = wb_pc4;
                imm            = j_imm;
            end
            op_jalr: begin
                ctrl.reg_write   = (funct3 == 3'b000);
                ctrl.is_jalr     = (funct3 == 3'b000);
                ctrl.alu_src_imm = 1'b1;  // ALU adds rs1 and offset
                ctrl.wb_sel      = wb_pc4;
            end
            default: ;
        endcase
    end

endmodule

// File: rv_hazard_unit.sv
module rv_hazard_unit (
    input  rv_pkg::reg_addr_t rs1_id,
    input  rv_pkg::reg_addr_t rs2_id,
    input  rv_pkg::id_ex_t    id_ex,
    input  rv_pkg::ex_mem_t   ex_mem,
    input  rv_pkg::mem_wb_t   mem_wb,
    input  logic              redirect,
    output logic              stall,
    output logic              flush_if_id,
    output logic              flush_id_ex,
    output rv_pkg::fwd_sel_t  fwd_a,
    output rv_pkg::fwd_sel_t  fwd_b
);

    import rv_pkg::*;

    logic load_use;

    // Memory stage is younger, so it wins over write-back
    function automatic fwd_sel_t pick_source(reg_addr_t src, ex_mem_t em, mem_wb_t mw);
        if (src == '0) begin
            return fwd_none;
        end
        if (em.valid && em.reg_write && (em.rd == src)) begin
            return fwd_mem;
        end
        if (mw.valid && mw.reg_write && (mw.rd == src)) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd_a = pick_source(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_source(id_ex.rs2, ex_mem, mem_wb);

    // Load in execute feeding the instruction in decode
    assign load_use = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rd != '0)
                      && ((id_ex.rd == rs1_id) || (id_ex.rd == rs2_id));

    // A redirect kills the dependent anyway, no need to hold
    assign stall       = load_use && !redirect;
    assign flush_if_id = redirect;
    assign flush_id_ex = redirect || load_use;

endmodule

// File: rv_pipe_reg.sv
module rv_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // All zeros is a bubble, the valid bit drops with everything else
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// File: rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // Major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // alu_add must stay at zero, a cleared ctrl_t is a bubble
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b,  // LUI
        alu_eq,      // BEQ compare
        alu_ne       // BNE compare
    } alu_op_t;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4
    } wb_sel_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;  // Operand b from immediate
        logic    is_branch;
        logic    is_jal;
        logic    is_jalr;
        alu_op_t alu_op;
        wb_sel_t wb_sel;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        ctrl_t     ctrl;
        logic      valid;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        wb_sel_t   wb_sel;
        logic      valid;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        word_t     alu_result;
        word_t     mem_data;
        reg_addr_t rd;
        logic      reg_write;
        wb_sel_t   wb_sel;
        logic      valid;
    } mem_wb_t;

    // ADDI x0, x0, 0
    localparam word_t nop_instruction = 32'h0000_0013;

endpackage

// File: rv_regfile.sv
module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  rv_pkg::reg_addr_t wr_addr,
    input  rv_pkg::word_t     wr_data,
    input  rv_pkg::reg_addr_t rd_addr_a,
    input  rv_pkg::reg_addr_t rd_addr_b,
    output rv_pkg::word_t     rd_data_a,
    output rv_pkg::word_t     rd_data_b,
    input  rv_pkg::reg_addr_t dbg_addr,
    output rv_pkg::word_t     dbg_data
);

    import rv_pkg::*;

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write shows through to decode
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) return '0;
        if (wr_en && (wr_addr == addr)) return wr_data;
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
        dbg_data  = read_port(dbg_addr);
    end

endmodule

// File: sim.f
rv_pkg.sv
rv_pipe_reg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_hazard_unit.sv
rv_core.sv
rv_core_asserts.sv
tb_rv_core.sv

// File: tb_rv_core.sv
module tb_rv_core;

    import rv_pkg::*;

    logic      clk;
    logic      reset;
    word_t     im_addr;
    word_t     inst;
    word_t     dm_addr;
    word_t     dm_wdata;
    logic      dm_wr;
    logic      dm_rd;
    word_t     dm_rdata;
    reg_addr_t reg_sel;
    word_t     reg_data;

    word_t     imem [64];
    word_t     dmem [64];
    word_t     prog_q [$];  // Program and expectation table
    reg_addr_t rd_q [$];
    word_t     val_q [$];
    word_t     exp_store;  // Word the SW leaves at address 8
    logic      done;
    int        cycles;
    int        cycle_limit;

    rv_core i_rv_core (
        .clk(clk), .reset(reset), .im_addr(im_addr), .inst(inst),
        .dm_addr(dm_addr), .dm_wdata(dm_wdata), .dm_wr(dm_wr), .dm_rd(dm_rd),
        .dm_rdata(dm_rdata), .reg_sel(reg_sel), .reg_data(reg_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign inst     = imem[im_addr[7:2]];
    assign dm_rdata = dm_rd ? dmem[dm_addr[7:2]] : 'x;  // Read data only on a load

    always @(posedge clk) begin
        if (dm_wr) dmem[dm_addr[7:2]] <= dm_wdata;
    end

    // Instruction formats
    function automatic word_t r_type(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                     reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_step(input word_t w, input reg_addr_t rd, input word_t val);
        prog_q.push_back(w);
        rd_q.push_back(rd);
        val_q.push_back(val);
    endtask

    task automatic build_program();
        logic [11:0] c1;
        logic [11:0] c2;
        logic [19:0] u;
        word_t       x1;
        word_t       x2;
        word_t       x3;
        word_t       x4;
        c1 = 12'($urandom);
        c2 = 12'($urandom);
        u  = 20'($urandom);
        x1 = {{20{c1[11]}}, c1};
        x2 = {{20{c2[11]}}, c2};
        x3 = x1 + x2;
        x4 = x3 - x1;
        exp_store = {u, 12'b0};
        add_step(i_type(c1, 0, 3'b000, 1, 7'b0010011), 1, x1);
        add_step(i_type(c2, 0, 3'b000, 2, 7'b0010011), 2, x2);
        add_step(r_type(7'h00, 2, 1, 3'b000, 3), 3, x3);  // Forward from mem and wb
        add_step(r_type(7'h20, 1, 3, 3'b000, 4), 4, x4);
        add_step(r_type(7'h00, 2, 1, 3'b111, 5), 5, x1 & x2);  // x2 through bypass
        add_step(r_type(7'h00, 2, 1, 3'b110, 6), 6, x1 | x2);
        add_step(r_type(7'h00, 4, 3, 3'b100, 7), 7, x3 ^ x4);
        add_step(r_type(7'h00, 2, 1, 3'b010, 8), 8, word_t'($signed(x1) < $signed(x2)));
        add_step({u, 5'd9, 7'b0110111}, 9, exp_store);
        add_step(s_type(12'd8, 9, 0), 0, '0);
        add_step(i_type(12'd8, 0, 3'b010, 10, 7'b0000011), 10, exp_store);
        add_step(r_type(7'h00, 1, 10, 3'b000, 11), 11, exp_store + x1);  // Load-use
        add_step(b_type(13'd12, 1, 1, 3'b000), 0, '0);  // BEQ taken
        add_step(i_type(12'd1, 0, 3'b000, 12, 7'b0010011), 12, '0);
        add_step(i_type(12'd1, 0, 3'b000, 13, 7'b0010011), 13, '0);
        add_step(b_type(13'd8, 1, 1, 3'b001), 0, '0);  // BNE falls through
        add_step(i_type(12'd5, 0, 3'b000, 14, 7'b0010011), 14, 32'd5);
        add_step(b_type(13'd12, 0, 14, 3'b001), 0, '0);
        add_step(i_type(12'd1, 0, 3'b000, 15, 7'b0010011), 15, '0);
        add_step(i_type(12'd1, 0, 3'b000, 16, 7'b0010011), 16, '0);
        add_step(j_type(21'd12, 17), 17, 32'd84);
        add_step(i_type(12'd1, 0, 3'b000, 18, 7'b0010011), 18, '0);
        add_step(i_type(12'd1, 0, 3'b000, 19, 7'b0010011), 19, '0);
        add_step(i_type(12'd108, 0, 3'b000, 21, 7'b0010011), 21, 32'd108);
        add_step(i_type(12'd0, 21, 3'b000, 20, 7'b1100111), 20, 32'd100);  // JALR to 108
        add_step(i_type(12'd1, 0, 3'b000, 22, 7'b0010011), 22, '0);
        add_step(i_type(12'd1, 0, 3'b000, 23, 7'b0010011), 23, '0);
        add_step(j_type(21'd0, 0), 0, '0);  // Final self-loop at 108
    endtask

    task automatic check(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // Run limit while the program executes
    always @(posedge clk) begin
        if (!reset && !done) begin
            cycles <= cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("Timeout: the program did not reach its final loop in %0d cycles",
                         cycle_limit);
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
        end
    end

    initial begin
        reset   = 1'b1;
        reg_sel = '0;
        done    = 1'b0;
        cycles  = 0;
        void'($urandom(30756));
        build_program();
        cycle_limit = 4 * prog_q.size() + 40;
        for (int i = 0; i < 64; i++) begin
            // Unused slots hold ADDI x0 with the word index as immediate
            imem[i] = (i < prog_q.size()) ? prog_q[i] : i_type(12'(i), 0, 3'b000, 0, 7'b0010011);
            dmem[i] = 32'ha5a5_0000 | word_t'(i);
        end
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        do @(negedge clk); while (im_addr != word_t'(4 * (prog_q.size() - 1)));
        repeat (4) @(negedge clk);  // Drain the jump ahead of the loop
        done = 1'b1;
        for (int i = 0; i < prog_q.size(); i++) begin
            @(posedge clk);
            reg_sel <= rd_q[i];
            @(negedge clk);
            check(reg_data, val_q[i], $sformatf("x%0d after instruction %0d", rd_q[i], i));
        end
        check(dmem[2], exp_store, "data memory word at address 8");
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
